// ==== logic/ray_box_pkg.sv ====
package ray_box_pkg;

	////////////////////////////////////////////////////////////////////////////
	// axis indexing
	////////////////////////////////////////////////////////////////////////////

	localparam int NUM_AXES = 3;  // x, y and z slabs
	localparam int AXIS_X = 0;
	localparam int AXIS_Y = 1;
	localparam int AXIS_Z = 2;

	////////////////////////////////////////////////////////////////////////////
	// pipeline depth
	////////////////////////////////////////////////////////////////////////////

	localparam int FEED_STAGES = 1;  // input register
	localparam int SLAB_STAGES = 3;  // subtract, multiply, order
	localparam int COMBINE_STAGES = 2;  // reduce, decide

	// cycles from an input edge to the matching hit
	localparam int HIT_LATENCY = FEED_STAGES + SLAB_STAGES + COMBINE_STAGES;

endpackage

// ==== logic/ray_box_ifs.sv ====
`timescale 1ns/1ps

// one axis of a ray and its box, feed stage to slab unit
interface ray_axis_if #(
	parameter int COORD_W = 32
) ();
	logic signed [COORD_W-1:0] origin;
	logic signed [COORD_W-1:0] box_min;
	logic signed [COORD_W-1:0] box_max;
	logic signed [COORD_W-1:0] inv_dir;  // 1/d in fixed point
	logic parallel;  // d is zero on this axis

	modport feed (
		output origin, box_min, box_max, inv_dir, parallel
	);

	modport slab (
		input origin, box_min, box_max, inv_dir, parallel
	);
endinterface

// slab interval of one axis, slab unit to combine stage
interface slab_if #(
	parameter int COORD_W = 32
) ();
	logic signed [COORD_W-1:0] t_enter;
	logic signed [COORD_W-1:0] t_exit;
	logic parallel;
	logic outside;  // origin not between the planes

	modport slab (
		output t_enter, t_exit, parallel, outside
	);

	modport combine (
		input t_enter, t_exit, parallel, outside
	);
endinterface

// ==== logic/ray_feed.sv ====
`timescale 1ns/1ps

module ray_feed #(
	parameter int COORD_W = 32
) (
	input logic clk,
	input logic rst,
	input logic signed [COORD_W-1:0] origin [ray_box_pkg::NUM_AXES],
	input logic signed [COORD_W-1:0] inv_dir [ray_box_pkg::NUM_AXES],
	input logic signed [COORD_W-1:0] box_min [ray_box_pkg::NUM_AXES],
	input logic signed [COORD_W-1:0] box_max [ray_box_pkg::NUM_AXES],
	input logic [ray_box_pkg::NUM_AXES-1:0] parallel,
	ray_axis_if.feed axis_x,
	ray_axis_if.feed axis_y,
	ray_axis_if.feed axis_z
);
	logic signed [COORD_W-1:0] origin_q [ray_box_pkg::NUM_AXES];
	logic signed [COORD_W-1:0] inv_dir_q [ray_box_pkg::NUM_AXES];
	logic signed [COORD_W-1:0] box_min_q [ray_box_pkg::NUM_AXES];
	logic signed [COORD_W-1:0] box_max_q [ray_box_pkg::NUM_AXES];
	logic [ray_box_pkg::NUM_AXES-1:0] parallel_q;

	// one register in front of the subtractors
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int a = 0; a < ray_box_pkg::NUM_AXES; a++) begin
				origin_q[a] <= '0;
				inv_dir_q[a] <= '0;
				box_min_q[a] <= '0;
				box_max_q[a] <= '0;
			end
			parallel_q <= '0;
		end else begin
			origin_q <= origin;
			inv_dir_q <= inv_dir;
			box_min_q <= box_min;
			box_max_q <= box_max;
			parallel_q <= parallel;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// fan out, one interface per axis
	////////////////////////////////////////////////////////////////////////////

	assign axis_x.origin = origin_q[ray_box_pkg::AXIS_X];
	assign axis_x.box_min = box_min_q[ray_box_pkg::AXIS_X];
	assign axis_x.box_max = box_max_q[ray_box_pkg::AXIS_X];
	assign axis_x.inv_dir = inv_dir_q[ray_box_pkg::AXIS_X];
	assign axis_x.parallel = parallel_q[ray_box_pkg::AXIS_X];

	assign axis_y.origin = origin_q[ray_box_pkg::AXIS_Y];
	assign axis_y.box_min = box_min_q[ray_box_pkg::AXIS_Y];
	assign axis_y.box_max = box_max_q[ray_box_pkg::AXIS_Y];
	assign axis_y.inv_dir = inv_dir_q[ray_box_pkg::AXIS_Y];
	assign axis_y.parallel = parallel_q[ray_box_pkg::AXIS_Y];

	assign axis_z.origin = origin_q[ray_box_pkg::AXIS_Z];
	assign axis_z.box_min = box_min_q[ray_box_pkg::AXIS_Z];
	assign axis_z.box_max = box_max_q[ray_box_pkg::AXIS_Z];
	assign axis_z.inv_dir = inv_dir_q[ray_box_pkg::AXIS_Z];
	assign axis_z.parallel = parallel_q[ray_box_pkg::AXIS_Z];

endmodule

// ==== logic/axis_slab.sv ====
`timescale 1ns/1ps

module axis_slab #(
	parameter int COORD_W = 32,
	parameter int FRAC_BITS = 16
) (
	input logic clk,
	input logic rst,
	ray_axis_if.slab ray,
	slab_if.slab times
);
	localparam int PROD_W = 2 * COORD_W;

	logic signed [COORD_W-1:0] lo_dist;  // box_min - origin
	logic signed [COORD_W-1:0] hi_dist;  // box_max - origin
	logic signed [COORD_W-1:0] inv_dir_d1;
	logic outside_d1;
	logic parallel_d1;

	logic signed [PROD_W-1:0] lo_full;
	logic signed [PROD_W-1:0] hi_full;
	logic signed [PROD_W-1:0] lo_scaled;
	logic signed [PROD_W-1:0] hi_scaled;
	logic signed [COORD_W-1:0] lo_prod;  // time at the min plane
	logic signed [COORD_W-1:0] hi_prod;  // time at the max plane
	logic neg_d2;
	logic outside_d2;
	logic parallel_d2;

	logic signed [COORD_W-1:0] t_enter_q;
	logic signed [COORD_W-1:0] t_exit_q;
	logic outside_d3;
	logic parallel_d3;

	////////////////////////////////////////////////////////////////////////////
	// stage 1, distances to both planes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lo_dist <= '0;
			hi_dist <= '0;
			inv_dir_d1 <= '0;
			outside_d1 <= 1'b0;
			parallel_d1 <= 1'b0;
		end else begin
			lo_dist <= ray.box_min - ray.origin;
			hi_dist <= ray.box_max - ray.origin;
			inv_dir_d1 <= ray.inv_dir;
			outside_d1 <= (ray.origin < ray.box_min) || (ray.origin > ray.box_max);
			parallel_d1 <= ray.parallel;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 2, scale by 1/d
	////////////////////////////////////////////////////////////////////////////

	assign lo_full = lo_dist * inv_dir_d1;  // full double-width product
	assign hi_full = hi_dist * inv_dir_d1;
	assign lo_scaled = lo_full >>> FRAC_BITS;  // back to the word's binary point
	assign hi_scaled = hi_full >>> FRAC_BITS;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lo_prod <= '0;
			hi_prod <= '0;
			neg_d2 <= 1'b0;
			outside_d2 <= 1'b0;
			parallel_d2 <= 1'b0;
		end else begin
			lo_prod <= lo_scaled[COORD_W-1:0];  // truncate, upper bits dropped
			hi_prod <= hi_scaled[COORD_W-1:0];
			neg_d2 <= inv_dir_d1[COORD_W-1];  // direction sign for the swap
			outside_d2 <= outside_d1;
			parallel_d2 <= parallel_d1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 3, entry and exit by direction
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			t_enter_q <= '0;
			t_exit_q <= '0;
			outside_d3 <= 1'b0;
			parallel_d3 <= 1'b0;
		end else begin
			t_enter_q <= neg_d2 ? hi_prod : lo_prod;  // negative d meets max plane first
			t_exit_q <= neg_d2 ? lo_prod : hi_prod;
			outside_d3 <= outside_d2;
			parallel_d3 <= parallel_d2;
		end
	end

	assign times.t_enter = t_enter_q;
	assign times.t_exit = t_exit_q;
	assign times.outside = outside_d3;
	assign times.parallel = parallel_d3;

endmodule

// ==== logic/slab_combine.sv ====
`timescale 1ns/1ps

module slab_combine #(
	parameter int COORD_W = 32
) (
	input logic clk,
	input logic rst,
	slab_if.combine slab_x,
	slab_if.combine slab_y,
	slab_if.combine slab_z,
	output logic hit
);
	localparam logic signed [COORD_W-1:0] T_MIN = {1'b1, {(COORD_W-1){1'b0}}};
	localparam logic signed [COORD_W-1:0] T_MAX = {1'b0, {(COORD_W-1){1'b1}}};

	logic signed [COORD_W-1:0] t_enter_a [ray_box_pkg::NUM_AXES];
	logic signed [COORD_W-1:0] t_exit_a [ray_box_pkg::NUM_AXES];
	logic [ray_box_pkg::NUM_AXES-1:0] par_a;
	logic [ray_box_pkg::NUM_AXES-1:0] out_a;

	logic signed [COORD_W-1:0] tnear_c;
	logic signed [COORD_W-1:0] tfar_c;
	logic signed [COORD_W-1:0] tnear_q;
	logic signed [COORD_W-1:0] tfar_q;
	logic blocked_q;
	logic all_parallel_q;

	// gather the three axes so the reduction can loop
	assign t_enter_a[ray_box_pkg::AXIS_X] = slab_x.t_enter;
	assign t_enter_a[ray_box_pkg::AXIS_Y] = slab_y.t_enter;
	assign t_enter_a[ray_box_pkg::AXIS_Z] = slab_z.t_enter;
	assign t_exit_a[ray_box_pkg::AXIS_X] = slab_x.t_exit;
	assign t_exit_a[ray_box_pkg::AXIS_Y] = slab_y.t_exit;
	assign t_exit_a[ray_box_pkg::AXIS_Z] = slab_z.t_exit;
	assign par_a[ray_box_pkg::AXIS_X] = slab_x.parallel;
	assign par_a[ray_box_pkg::AXIS_Y] = slab_y.parallel;
	assign par_a[ray_box_pkg::AXIS_Z] = slab_z.parallel;
	assign out_a[ray_box_pkg::AXIS_X] = slab_x.outside;
	assign out_a[ray_box_pkg::AXIS_Y] = slab_y.outside;
	assign out_a[ray_box_pkg::AXIS_Z] = slab_z.outside;

	////////////////////////////////////////////////////////////////////////////
	// stage 1, interval intersection
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		tnear_c = T_MIN;  // no axis constrains yet
		tfar_c = T_MAX;
		for (int a = 0; a < ray_box_pkg::NUM_AXES; a++) begin
			if (!par_a[a]) begin  // parallel axes add no bound
				if (t_enter_a[a] > tnear_c)
					tnear_c = t_enter_a[a];
				if (t_exit_a[a] < tfar_c)
					tfar_c = t_exit_a[a];
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			tnear_q <= '0;
			tfar_q <= '0;
			blocked_q <= 1'b0;
			all_parallel_q <= 1'b0;
		end else begin
			tnear_q <= tnear_c;
			tfar_q <= tfar_c;
			blocked_q <= |(par_a & out_a);  // parallel and outside, never reaches box
			all_parallel_q <= &par_a;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 2, hit decision
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			hit <= 1'b0;
		end else begin
			hit <= !blocked_q && (all_parallel_q || ((tfar_q >= tnear_q) && (tfar_q > 0)));
		end
	end

endmodule

// ==== logic/ray_box_top.sv ====
`timescale 1ns/1ps

// ray against box slab test, one ray per clock, hit after
// ray_box_pkg::HIT_LATENCY cycles
module ray_box_top #(
	parameter int COORD_W = 32,
	parameter int FRAC_BITS = 16
) (
	input logic clk,
	input logic rst,
	input logic signed [COORD_W-1:0] origin [ray_box_pkg::NUM_AXES],
	input logic signed [COORD_W-1:0] inv_dir [ray_box_pkg::NUM_AXES],
	input logic signed [COORD_W-1:0] box_min [ray_box_pkg::NUM_AXES],
	input logic signed [COORD_W-1:0] box_max [ray_box_pkg::NUM_AXES],
	input logic [ray_box_pkg::NUM_AXES-1:0] parallel,
	output logic hit
);

	////////////////////////////////////////////////////////////////////////////
	// per-axis links
	////////////////////////////////////////////////////////////////////////////

	ray_axis_if #(.COORD_W(COORD_W)) ray_if [ray_box_pkg::NUM_AXES] ();
	slab_if #(.COORD_W(COORD_W)) times_if [ray_box_pkg::NUM_AXES] ();

	// input register, 1 stage
	ray_feed #(
		.COORD_W(COORD_W)
	) u_feed (
		.clk(clk),
		.rst(rst),
		.origin(origin),
		.inv_dir(inv_dir),
		.box_min(box_min),
		.box_max(box_max),
		.parallel(parallel),
		.axis_x(ray_if[ray_box_pkg::AXIS_X]),
		.axis_y(ray_if[ray_box_pkg::AXIS_Y]),
		.axis_z(ray_if[ray_box_pkg::AXIS_Z])
	);

	// slab units, 3 stages each
	for (genvar a = 0; a < ray_box_pkg::NUM_AXES; a++) begin : g_axis
		axis_slab #(
			.COORD_W(COORD_W),
			.FRAC_BITS(FRAC_BITS)
		) u_slab (
			.clk(clk),
			.rst(rst),
			.ray(ray_if[a]),
			.times(times_if[a])
		);
	end

	// reduce and decide, 2 stages
	slab_combine #(
		.COORD_W(COORD_W)
	) u_combine (
		.clk(clk),
		.rst(rst),
		.slab_x(times_if[ray_box_pkg::AXIS_X]),
		.slab_y(times_if[ray_box_pkg::AXIS_Y]),
		.slab_z(times_if[ray_box_pkg::AXIS_Z]),
		.hit(hit)
	);

endmodule

// ==== verification/ray_box_assertions.sv ====
`timescale 1ns/1ps

module ray_box_assertions #(
	parameter int COORD_W = 32,
	parameter int FRAC_BITS = 16
) (
	input logic clk,
	input logic rst,
	input logic signed [COORD_W-1:0] origin [ray_box_pkg::NUM_AXES],
	input logic signed [COORD_W-1:0] inv_dir [ray_box_pkg::NUM_AXES],
	input logic signed [COORD_W-1:0] box_min [ray_box_pkg::NUM_AXES],
	input logic signed [COORD_W-1:0] box_max [ray_box_pkg::NUM_AXES],
	input logic [ray_box_pkg::NUM_AXES-1:0] parallel,
	input logic hit
);
	localparam int LAT = ray_box_pkg::HIT_LATENCY;

	logic hit_now;  // rule applied to the ray at the pins
	logic exp_dly [LAT];  // expected hit, aged one slot per edge
	int settle;  // edges since reset release, saturates at LAT
	int fail_count = 0;

	////////////////////////////////////////////////////////////////////////////
	// slab rule on the sampled ray
	////////////////////////////////////////////////////////////////////////////

	always_comb begin : hit_rule
		logic signed [COORD_W-1:0] d_lo;
		logic signed [COORD_W-1:0] d_hi;
		logic signed [2*COORD_W-1:0] p_lo;
		logic signed [2*COORD_W-1:0] p_hi;
		logic signed [COORD_W-1:0] t_in;
		logic signed [COORD_W-1:0] t_out;
		logic signed [COORD_W-1:0] t_near;
		logic signed [COORD_W-1:0] t_far;
		logic blocked;
		logic all_par;
		t_near = {1'b1, {(COORD_W-1){1'b0}}};  // most negative word
		t_far = {1'b0, {(COORD_W-1){1'b1}}};  // most positive word
		blocked = 1'b0;
		all_par = 1'b1;
		for (int a = 0; a < ray_box_pkg::NUM_AXES; a++) begin
			d_lo = box_min[a] - origin[a];
			d_hi = box_max[a] - origin[a];
			p_lo = (2*COORD_W)'(d_lo) * (2*COORD_W)'(inv_dir[a]);
			p_hi = (2*COORD_W)'(d_hi) * (2*COORD_W)'(inv_dir[a]);
			t_in = (inv_dir[a] < 0) ? p_hi[FRAC_BITS +: COORD_W] : p_lo[FRAC_BITS +: COORD_W];
			t_out = (inv_dir[a] < 0) ? p_lo[FRAC_BITS +: COORD_W] : p_hi[FRAC_BITS +: COORD_W];
			if (parallel[a]) begin
				if ((origin[a] < box_min[a]) || (origin[a] > box_max[a]))
					blocked = 1'b1;  // never enters this slab
			end else begin
				all_par = 1'b0;
				if (t_in > t_near)
					t_near = t_in;
				if (t_out < t_far)
					t_far = t_out;
			end
		end
		hit_now = !blocked && (all_par || ((t_far >= t_near) && (t_far > 0)));
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < LAT; i++)
				exp_dly[i] <= 1'b0;
			settle <= 0;
		end else begin
			exp_dly[0] <= hit_now;
			for (int i = 1; i < LAT; i++)
				exp_dly[i] <= exp_dly[i-1];
			if (settle < LAT)
				settle <= settle + 1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_quiet_after_reset: assert property (
		@(posedge clk) (rst || (settle < LAT)) |-> !hit
	) else begin
		fail_count++;
		$error("FAIL t=%0t hit expected 0 got %0b", $time, $sampled(hit));
	end

	a_hit_known: assert property (
		@(posedge clk) disable iff (rst) !$isunknown(hit)
	) else begin
		fail_count++;
		$error("FAIL t=%0t hit expected 0 or 1 got %0b", $time, $sampled(hit));
	end

	a_hit_rule: assert property (
		@(posedge clk) disable iff (rst) (settle == LAT) |-> (hit == exp_dly[LAT-1])
	) else begin
		fail_count++;
		$error("FAIL t=%0t hit expected %0b got %0b", $time,
			$sampled(exp_dly[LAT-1]), $sampled(hit));
	end

endmodule

bind ray_box_top ray_box_assertions #(
	.COORD_W(COORD_W),
	.FRAC_BITS(FRAC_BITS)
) u_assert (
	.clk(clk),
	.rst(rst),
	.origin(origin),
	.inv_dir(inv_dir),
	.box_min(box_min),
	.box_max(box_max),
	.parallel(parallel),
	.hit(hit)
);

// ==== verification/ray_box_tb.sv ====
`timescale 1ns/1ps

module ray_box_tb;
	localparam int COORD_W = 32;
	localparam int FRAC_BITS = 16;
	localparam int RESET_CYCLES = 10;
	localparam int NUM_DIRECTED = 12;
	localparam int NUM_RANDOM = 300;
	localparam int MARGIN_CYCLES = 20;
	localparam int TIMEOUT_NS = (NUM_DIRECTED + NUM_RANDOM + ray_box_pkg::HIT_LATENCY
		+ RESET_CYCLES + MARGIN_CYCLES) * 10;

	logic clk;
	logic rst;
	logic signed [COORD_W-1:0] origin [ray_box_pkg::NUM_AXES];
	logic signed [COORD_W-1:0] inv_dir [ray_box_pkg::NUM_AXES];
	logic signed [COORD_W-1:0] box_min [ray_box_pkg::NUM_AXES];
	logic signed [COORD_W-1:0] box_max [ray_box_pkg::NUM_AXES];
	logic [ray_box_pkg::NUM_AXES-1:0] parallel;
	logic hit;
	int seed;

	ray_box_top #(
		.COORD_W(COORD_W),
		.FRAC_BITS(FRAC_BITS)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.origin(origin),
		.inv_dir(inv_dir),
		.box_min(box_min),
		.box_max(box_max),
		.parallel(parallel),
		.hit(hit)
	);

	always #5 clk = ~clk;  // 10 ns period

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic next_edge();
		@(posedge clk);
		#1;  // inputs change clear of the edge
	endtask

	task automatic load_axis(input int a, input logic signed [COORD_W-1:0] org,
		input logic signed [COORD_W-1:0] inv, input logic signed [COORD_W-1:0] lo,
		input logic signed [COORD_W-1:0] hi, input logic par);
		origin[a] = org;
		inv_dir[a] = inv;
		box_min[a] = lo;
		box_max[a] = hi;
		parallel[a] = par;
	endtask

	// whole units, shifted to the binary point
	task automatic place_axis(input int a, input int org, input int inv, input int lo,
		input int hi, input logic par);
		load_axis(a, org <<< FRAC_BITS, inv <<< FRAC_BITS, lo <<< FRAC_BITS,
			hi <<< FRAC_BITS, par);
	endtask

	task automatic clear_ray();
		for (int a = 0; a < ray_box_pkg::NUM_AXES; a++)
			load_axis(a, 0, 0, 0, 0, 1'b0);
	endtask

	// raw coordinates under 2^10, inverse directions under 64.0
	task automatic random_ray();
		int o;
		int m;
		int n;
		int iv;
		logic par;
		for (int a = 0; a < ray_box_pkg::NUM_AXES; a++) begin
			o = $random(seed) % 1024;
			m = $random(seed) % 1024;
			n = $random(seed) % 1024;
			iv = $random(seed) % (1 << 22);
			par = (($random(seed) & 7) == 0);  // about one axis in eight
			if (par)
				iv = 0;
			if (m > n)
				load_axis(a, o, iv, n, m, par);
			else
				load_axis(a, o, iv, m, n, par);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// watchdog and failure watch
	////////////////////////////////////////////////////////////////////////////

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("sim failed");
		$fatal(1, "timeout, the ray sequence did not finish in time");
	end

	initial begin : failure_watch
		wait (u_dut.u_assert.fail_count != 0);
		$display("sim failed");
		$fatal(1, "a hit check assertion failed");
	end

	////////////////////////////////////////////////////////////////////////////
	// sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		seed = 47;
		for (int a = 0; a < ray_box_pkg::NUM_AXES; a++)
			place_axis(a, 3, 1, 2, 4, 1'b0);  // a hitting ray held through reset
		repeat (RESET_CYCLES) @(posedge clk);
		#1 rst = 1'b0;

		// directed rays, back to back
		next_edge();  // negative x direction through the box
		place_axis(0, 10, -1, 2, 4, 1'b0);
		place_axis(1, 3, 16, 2, 4, 1'b0);
		place_axis(2, 3, 16, 2, 4, 1'b0);
		next_edge();  // beyond the box, pointing away
		place_axis(0, 10, 1, 2, 4, 1'b0);
		next_edge();  // box wholly behind the origin
		place_axis(0, 0, 1, -4, -2, 1'b0);
		next_edge();  // origin inside the box
		place_axis(0, 3, 1, 2, 4, 1'b0);
		next_edge();  // negative y direction
		place_axis(0, 3, 16, 2, 4, 1'b0);
		place_axis(1, 10, -2, 2, 4, 1'b0);
		next_edge();  // parallel x outside blocks a hit
		place_axis(0, 10, 0, 2, 4, 1'b1);
		place_axis(1, 3, 1, 2, 4, 1'b0);
		next_edge();  // parallel x inside, others hit
		place_axis(0, 3, 0, 2, 4, 1'b1);
		next_edge();  // parallel x inside, y misses
		place_axis(1, 10, 1, 2, 4, 1'b0);
		next_edge();  // all parallel, inside
		place_axis(1, 3, 0, 2, 4, 1'b1);
		place_axis(2, 3, 0, 2, 4, 1'b1);
		next_edge();  // all parallel, z outside
		place_axis(2, 5, 0, 2, 4, 1'b1);
		next_edge();  // all parallel, origin on the faces
		place_axis(0, 2, 0, 2, 4, 1'b1);
		place_axis(1, 4, 0, 2, 4, 1'b1);
		place_axis(2, 3, 0, 2, 4, 1'b1);
		next_edge();  // tfar equals tnear
		place_axis(0, 0, 1, 2, 4, 1'b0);
		place_axis(1, 0, 1, 4, 6, 1'b0);

		for (int i = 0; i < NUM_RANDOM; i++) begin
			next_edge();
			random_ray();
		end

		next_edge();
		clear_ray();
		repeat (ray_box_pkg::HIT_LATENCY + 1) @(posedge clk);  // drain the pipeline
		#1;  // checks of the last edge settle

		if (u_dut.u_assert.fail_count == 0) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("sim failed");
			$fatal(1, "hit checks reported %0d failures", u_dut.u_assert.fail_count);
		end
	end

endmodule

// ==== build.f ====
logic/ray_box_pkg.sv
logic/ray_box_ifs.sv
logic/ray_feed.sv
logic/axis_slab.sv
logic/slab_combine.sv
logic/ray_box_top.sv
verification/ray_box_assertions.sv
verification/ray_box_tb.sv

// ==== Makefile ====
TOP := ray_box_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module ray_box_top -f build.f

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then \
		echo "FAILED, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
